// File: files.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/read_request_fsm.sv
hdl/image_buffer.sv
hdl/kernel_bank_buffer.sv
hdl/spectral_mac.sv
hdl/write_request_queue.sv
hdl/conv_afu_top.sv
testbench/conv_afu_tb.sv

// File: hdl/conv_afu_top.sv
// top level of the spectral convolution core
// read sequencer, image and kernel buffers, MAC engine and write queue

`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_afu_top (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        start,
  input  wire conv_pkg::addr_t       image_addr,
  input  wire conv_pkg::addr_t       kernel_addr,
  input  wire conv_pkg::addr_t       dest_addr,
  input  wire conv_pkg::map_idx_t    num_maps,
  input  wire conv_pkg::filter_cnt_t num_filters,
  output logic                       rd_req_en,
  output conv_pkg::addr_t            rd_req_addr,
  output logic                       rd_req_tag,
  input  wire                        rd_req_almostfull,
  input  wire                        rd_rsp_valid,
  input  wire                        rd_rsp_tag,
  input  wire conv_pkg::cl_t         rd_rsp_data,
  output logic                       wr_req_en,
  output conv_pkg::addr_t            wr_req_addr,
  output conv_pkg::cl_t              wr_req_data,
  input  wire                        wr_req_almostfull,
  output logic                       done
);

  // bank handshake between the filter store and the MAC
  logic                 bank_vacant_any;
  logic                 bank_ready;
  logic                 bank_sel;
  logic                 bank_release;

  logic [`MAP_BITS-1:0] img_rd_idx;
  logic [`MAP_BITS:0]   ker_rd_idx;
  conv_pkg::cl_t        img_rd_data;
  conv_pkg::cl_t        ker_rd_data;
  conv_pkg::map_idx_t   img_count;

  logic                 res_valid;
  logic                 res_ready;
  conv_pkg::cl_t        res_data;

  read_request_fsm    u_read_fsm    (.*);
  image_buffer        u_image_buf   (.*);
  kernel_bank_buffer  u_kernel_buf  (.*);
  spectral_mac        u_mac         (.*);
  write_request_queue u_write_queue (.*);

endmodule

`default_nettype wire

// File: hdl/conv_defines.svh
// widths, depths and fixed-point scaling for the spectral convolution core

`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// one cacheline holds two complex lanes
`define CL_BITS        64
`define LANES          2
`define PART_BITS      16
`define ACC_BITS       40
`define FRAC_BITS      8

`define ADDR_BITS      16
// up to 16 input feature maps
`define MAP_BITS       4
`define OUT_FIFO_DEPTH 4

`endif

// File: hdl/conv_pkg.sv
// vector typedefs and FSM encodings shared by the convolution core

`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

  typedef logic [`CL_BITS-1:0]          cl_t;
  typedef logic signed [`PART_BITS-1:0] part_t;
  typedef logic signed [`ACC_BITS-1:0]  acc_t;
  typedef logic [`ADDR_BITS-1:0]        addr_t;
  // one extra bit so a count can reach the full map depth
  typedef logic [`MAP_BITS:0]           map_idx_t;
  typedef logic [7:0]                   filter_cnt_t;

  typedef enum logic [1:0] {bank_vacant, bank_filling, bank_full, bank_draining} bank_state_t;

  typedef enum logic [2:0] {rd_idle, rd_image, rd_wait_bank, rd_kernel, rd_finished} read_state_t;

  typedef enum logic [1:0] {mac_idle, mac_run, mac_emit} mac_state_t;

endpackage

`default_nettype wire

// File: hdl/image_buffer.sv
// image line store
// responses tagged 0 land in arrival order, read back by map index

`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module image_buffer (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     start,
  input  wire                     rd_rsp_valid,
  input  wire                     rd_rsp_tag,
  input  wire conv_pkg::cl_t      rd_rsp_data,
  input  wire [`MAP_BITS-1:0]     img_rd_idx,
  output conv_pkg::cl_t           img_rd_data,
  output conv_pkg::map_idx_t      img_count
);

  conv_pkg::cl_t mem [2**`MAP_BITS];
  logic          img_we;

  assign img_we = rd_rsp_valid && !rd_rsp_tag;

  // count doubles as the write pointer
  always_ff @(posedge clk) begin
    if (reset || start) begin
      img_count <= '0;
    end else if (img_we) begin
      img_count <= img_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (img_we) begin
      mem[img_count[`MAP_BITS-1:0]] <= rd_rsp_data;
    end
    img_rd_data <= mem[img_rd_idx];
  end

endmodule

`default_nettype wire

// File: hdl/kernel_bank_buffer.sv
// double-buffered filter store
// two banks of map lines, each with its own status FSM, drained in fill order

`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module kernel_bank_buffer (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     start,
  input  wire conv_pkg::map_idx_t num_maps,
  input  wire                     rd_rsp_valid,
  input  wire                     rd_rsp_tag,
  input  wire conv_pkg::cl_t      rd_rsp_data,
  input  wire [`MAP_BITS:0]       ker_rd_idx,
  input  wire                     bank_release,
  output conv_pkg::cl_t           ker_rd_data,
  output logic                    bank_ready,
  output logic                    bank_sel,
  output logic                    bank_vacant_any
);

  // bank index is the top address bit
  conv_pkg::cl_t          mem [2**(`MAP_BITS+1)];
  conv_pkg::bank_state_t  state [2];
  conv_pkg::map_idx_t     wr_idx;
  logic                   wr_bank;
  logic                   rd_bank;
  logic                   ker_we;
  logic                   wr_last;

  assign ker_we  = rd_rsp_valid && rd_rsp_tag;
  assign wr_last = (wr_idx == num_maps - 1'b1);

  // only one bank is handed out at a time
  assign bank_ready      = (state[rd_bank] == conv_pkg::bank_full) &&
                           (state[!rd_bank] != conv_pkg::bank_draining);
  assign bank_sel        = rd_bank;
  assign bank_vacant_any = (state[0] == conv_pkg::bank_vacant) ||
                           (state[1] == conv_pkg::bank_vacant);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_idx  <= '0;
      wr_bank <= 1'b0;
      rd_bank <= 1'b0;
      for (int b = 0; b < 2; b++) begin
        state[b] <= conv_pkg::bank_vacant;
      end
    end else begin
      if (start) begin
        wr_idx  <= '0;
        wr_bank <= 1'b0;
        rd_bank <= 1'b0;
      end else begin
        if (ker_we) begin
          wr_idx  <= wr_last ? '0 : wr_idx + 1'b1;
          wr_bank <= wr_last ? !wr_bank : wr_bank;
        end
        if (bank_ready) begin
          rd_bank <= !rd_bank;
        end
      end
      for (int b = 0; b < 2; b++) begin
        case (state[b])
          conv_pkg::bank_vacant, conv_pkg::bank_filling: begin
            if (ker_we && wr_bank == b[0]) begin
              state[b] <= wr_last ? conv_pkg::bank_full : conv_pkg::bank_filling;
            end
          end
          conv_pkg::bank_full: begin
            if (bank_ready && rd_bank == b[0]) begin
              state[b] <= conv_pkg::bank_draining;
            end
          end
          conv_pkg::bank_draining: begin
            if (bank_release) begin
              state[b] <= conv_pkg::bank_vacant;
            end
          end
          default: state[b] <= conv_pkg::bank_vacant;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ker_we) begin
      mem[{wr_bank, wr_idx[`MAP_BITS-1:0]}] <= rd_rsp_data;
    end
    ker_rd_data <= mem[ker_rd_idx];
  end

  // the read sequencer must never overrun a bank still holding filter data
  assert property (@(posedge clk) disable iff (reset)
    ker_we |-> (state[wr_bank] inside {conv_pkg::bank_vacant, conv_pkg::bank_filling}));

endmodule

`default_nettype wire

// File: hdl/read_request_fsm.sv
// read request sequencer
// one image phase, then one filter phase per filter, gated by almost-full

`timescale 1ns/1ps
`default_nettype none

module read_request_fsm (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       start,
  input  wire conv_pkg::addr_t      image_addr,
  input  wire conv_pkg::addr_t      kernel_addr,
  input  wire conv_pkg::map_idx_t   num_maps,
  input  wire conv_pkg::filter_cnt_t num_filters,
  input  wire                       rd_req_almostfull,
  input  wire                       bank_vacant_any,
  output logic                      rd_req_en,
  output conv_pkg::addr_t           rd_req_addr,
  output logic                      rd_req_tag
);

  conv_pkg::read_state_t  state;
  conv_pkg::map_idx_t     line_cnt;
  conv_pkg::filter_cnt_t  filt_cnt;
  conv_pkg::addr_t        ker_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= conv_pkg::rd_idle;
      rd_req_en <= 1'b0;
      line_cnt  <= '0;
      filt_cnt  <= '0;
    end else begin
      rd_req_en <= 1'b0;
      case (state)
        conv_pkg::rd_idle, conv_pkg::rd_finished: begin
          if (start) begin
            line_cnt <= '0;
            filt_cnt <= '0;
            ker_ptr  <= kernel_addr;
            state    <= conv_pkg::rd_image;
          end
        end
        conv_pkg::rd_image: begin
          if (!rd_req_almostfull) begin
            rd_req_en   <= 1'b1;
            rd_req_addr <= image_addr + conv_pkg::addr_t'(line_cnt);
            rd_req_tag  <= 1'b0;
            line_cnt    <= line_cnt + 1'b1;
            if (line_cnt == num_maps - 1'b1) begin
              line_cnt <= '0;
              state    <= conv_pkg::rd_wait_bank;
            end
          end
        end
        // a filter phase needs a whole bank to land in
        conv_pkg::rd_wait_bank: begin
          if (bank_vacant_any) begin
            state <= conv_pkg::rd_kernel;
          end
        end
        conv_pkg::rd_kernel: begin
          if (!rd_req_almostfull) begin
            rd_req_en   <= 1'b1;
            rd_req_addr <= ker_ptr;
            rd_req_tag  <= 1'b1;
            ker_ptr     <= ker_ptr + 1'b1;
            line_cnt    <= line_cnt + 1'b1;
            if (line_cnt == num_maps - 1'b1) begin
              line_cnt <= '0;
              filt_cnt <= filt_cnt + 1'b1;
              if (filt_cnt == num_filters - 1'b1) begin
                state <= conv_pkg::rd_finished;
              end else begin
                state <= conv_pkg::rd_wait_bank;
              end
            end
          end
        end
        default: state <= conv_pkg::rd_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/spectral_mac.sv
// spectral multiply-accumulate engine
// multiplies one full kernel bank against the image, summed over feature maps

`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module spectral_mac (
  input  wire                     clk,
  input  wire                     reset,
  input  wire conv_pkg::map_idx_t num_maps,
  input  wire conv_pkg::map_idx_t img_count,
  input  wire                     bank_ready,
  input  wire                     bank_sel,
  input  wire conv_pkg::cl_t      ker_rd_data,
  input  wire conv_pkg::cl_t      img_rd_data,
  input  wire                     res_ready,
  output logic [`MAP_BITS-1:0]    img_rd_idx,
  output logic [`MAP_BITS:0]      ker_rd_idx,
  output logic                    bank_release,
  output logic                    res_valid,
  output conv_pkg::cl_t           res_data
);

  localparam int LANE_BITS = 2 * `PART_BITS;

  conv_pkg::mac_state_t state;
  conv_pkg::map_idx_t   rd_idx;
  logic                 cur_bank;
  logic                 rd_pend;
  logic                 img_ready;
  logic                 finish;
  conv_pkg::acc_t       acc_re [`LANES];
  conv_pkg::acc_t       acc_im [`LANES];
  conv_pkg::acc_t       prod_re [`LANES];
  conv_pkg::acc_t       prod_im [`LANES];
  conv_pkg::cl_t        res_next;

  assign img_ready  = (img_count == num_maps);
  assign img_rd_idx = rd_idx[`MAP_BITS-1:0];
  assign ker_rd_idx = {cur_bank, rd_idx[`MAP_BITS-1:0]};
  // all reads issued and the last product already summed
  assign finish     = (state == conv_pkg::mac_run) && (rd_idx == num_maps) && !rd_pend;

  always_comb begin
    conv_pkg::part_t                ar, ai, br, bi;
    logic signed [LANE_BITS-1:0]    rr, ii, ri, ir;
    conv_pkg::acc_t                 sum_re, sum_im;
    res_next = '0;
    for (int k = 0; k < `LANES; k++) begin
      ar = img_rd_data[LANE_BITS*k +: `PART_BITS];
      ai = img_rd_data[LANE_BITS*k + `PART_BITS +: `PART_BITS];
      br = ker_rd_data[LANE_BITS*k +: `PART_BITS];
      bi = ker_rd_data[LANE_BITS*k + `PART_BITS +: `PART_BITS];
      rr = ar * br;
      ii = ai * bi;
      ri = ar * bi;
      ir = ai * br;
      prod_re[k] = conv_pkg::acc_t'(rr) - conv_pkg::acc_t'(ii);
      prod_im[k] = conv_pkg::acc_t'(ri) + conv_pkg::acc_t'(ir);
      // rescale back to the part format, upper bits dropped
      sum_re = acc_re[k] >>> `FRAC_BITS;
      sum_im = acc_im[k] >>> `FRAC_BITS;
      res_next[LANE_BITS*k +: `PART_BITS]              = sum_re[`PART_BITS-1:0];
      res_next[LANE_BITS*k + `PART_BITS +: `PART_BITS] = sum_im[`PART_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= conv_pkg::mac_idle;
      rd_idx       <= '0;
      cur_bank     <= 1'b0;
      rd_pend      <= 1'b0;
      res_valid    <= 1'b0;
      bank_release <= 1'b0;
    end else begin
      rd_pend      <= 1'b0;
      bank_release <= 1'b0;
      case (state)
        conv_pkg::mac_idle: begin
          if (bank_ready) begin
            cur_bank <= bank_sel;
            rd_idx   <= '0;
            state    <= conv_pkg::mac_run;
          end
        end
        conv_pkg::mac_run: begin
          if (rd_idx != num_maps) begin
            if (img_ready) begin
              rd_pend <= 1'b1;
              rd_idx  <= rd_idx + 1'b1;
            end
          end else if (!rd_pend) begin
            res_valid <= 1'b1;
            state     <= conv_pkg::mac_emit;
          end
        end
        // bank stays claimed until the result is accepted
        conv_pkg::mac_emit: begin
          if (res_ready) begin
            res_valid    <= 1'b0;
            bank_release <= 1'b1;
            state        <= conv_pkg::mac_idle;
          end
        end
        default: state <= conv_pkg::mac_idle;
      endcase
    end
  end

  // read data arrives one cycle after the index, hence rd_pend
  always_ff @(posedge clk) begin
    for (int k = 0; k < `LANES; k++) begin
      if (state == conv_pkg::mac_idle) begin
        acc_re[k] <= '0;
        acc_im[k] <= '0;
      end else if (rd_pend) begin
        acc_re[k] <= acc_re[k] + prod_re[k];
        acc_im[k] <= acc_im[k] + prod_im[k];
      end
    end
    if (finish) begin
      res_data <= res_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/write_request_queue.sv
// output FIFO and write request path
// lines go to dest_addr plus filter index, done after the last write

`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module write_request_queue (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        start,
  input  wire conv_pkg::addr_t       dest_addr,
  input  wire conv_pkg::filter_cnt_t num_filters,
  input  wire                        res_valid,
  input  wire conv_pkg::cl_t         res_data,
  input  wire                        wr_req_almostfull,
  output logic                       res_ready,
  output logic                       wr_req_en,
  output conv_pkg::addr_t            wr_req_addr,
  output conv_pkg::cl_t              wr_req_data,
  output logic                       done
);

  localparam int PTR_BITS = $clog2(`OUT_FIFO_DEPTH);

  conv_pkg::cl_t          fifo_mem [`OUT_FIFO_DEPTH];
  logic [PTR_BITS-1:0]    wr_ptr;
  logic [PTR_BITS-1:0]    rd_ptr;
  logic [PTR_BITS:0]      count;
  conv_pkg::filter_cnt_t  wr_cnt;
  logic                   push;
  logic                   pop;

  assign res_ready = (count != (PTR_BITS+1)'(`OUT_FIFO_DEPTH));
  assign push      = res_valid && res_ready;
  assign pop       = (count != '0) && !wr_req_almostfull;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      wr_cnt    <= '0;
      wr_req_en <= 1'b0;
      done      <= 1'b0;
    end else begin
      wr_req_en <= pop;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (start) begin
        wr_cnt <= '0;
        done   <= 1'b0;
      end else if (pop) begin
        wr_cnt <= wr_cnt + 1'b1;
        // rises together with the final write request
        if (wr_cnt == num_filters - 1'b1) begin
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= res_data;
    end
    if (pop) begin
      wr_req_data <= fifo_mem[rd_ptr];
      wr_req_addr <= dest_addr + conv_pkg::addr_t'(wr_cnt);
    end
  end

  // a result offered to a full queue is held by the MAC, not dropped
  assert property (@(posedge clk) disable iff (reset)
    res_valid && !res_ready |=> res_valid && $stable(res_data));

endmodule

`default_nettype wire

// File: testbench/conv_afu_tb.sv
// testbench for the spectral convolution core
// trace-driven jobs, in-order memory model with random delay and almost-full
// checks on read requests, write requests and done

`timescale 1ns/1ps
`default_nettype none

module conv_afu_tb;

  localparam int TRACE_WORDS = 256;

  logic                  clk;
  logic                  reset;
  logic                  start;
  conv_pkg::addr_t       image_addr;
  conv_pkg::addr_t       kernel_addr;
  conv_pkg::addr_t       dest_addr;
  conv_pkg::map_idx_t    num_maps;
  conv_pkg::filter_cnt_t num_filters;
  logic                  rd_req_en;
  conv_pkg::addr_t       rd_req_addr;
  logic                  rd_req_tag;
  logic                  rd_req_almostfull;
  logic                  rd_rsp_valid;
  logic                  rd_rsp_tag;
  conv_pkg::cl_t         rd_rsp_data;
  logic                  wr_req_en;
  conv_pkg::addr_t       wr_req_addr;
  conv_pkg::cl_t         wr_req_data;
  logic                  wr_req_almostfull;
  logic                  done;

  conv_pkg::cl_t   trace_mem [TRACE_WORDS];
  conv_pkg::cl_t   shared_mem [2**16];
  conv_pkg::addr_t exp_rd_addr [$];
  logic            exp_rd_tag [$];
  conv_pkg::addr_t exp_wr_addr [$];
  conv_pkg::cl_t   exp_wr_data [$];
  // read requests waiting in the memory model
  conv_pkg::addr_t rsp_addr [$];
  logic            rsp_tag [$];
  int              rsp_due [$];

  integer seed = 48;
  int     cycle;
  int     cycle_limit;
  int     wr_seen;
  int     wr_target;
  logic   done_chk;
  logic   rd_af_seen;
  logic   wr_af_seen;
  int     line_errors;
  int     addr_errors;
  int     flag_errors;
  int     other_errors;

  conv_afu_top uut (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // lane 0 real and lane 1 imaginary both carry the line address
  function automatic conv_pkg::cl_t fill_line(input conv_pkg::addr_t a);
    return {a, 16'h0000, 16'h0000, a};
  endfunction

  task automatic check_line(input string name, input conv_pkg::cl_t got,
                            input conv_pkg::cl_t exp);
    if (got !== exp) begin
      line_errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input conv_pkg::addr_t got,
                            input conv_pkg::addr_t exp);
    if (got !== exp) begin
      addr_errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("error counts: line %0d, addr %0d, flag %0d, other %0d",
             line_errors, addr_errors, flag_errors, other_errors);
  endtask

  // memory model and random back-pressure on both request paths
  always @(posedge clk) begin
    conv_pkg::addr_t a;
    logic            t;
    rd_req_almostfull <= (($random(seed) & 3) == 0);
    wr_req_almostfull <= (($random(seed) & 3) == 0);
    rd_af_seen        <= rd_req_almostfull;
    wr_af_seen        <= wr_req_almostfull;
    rd_rsp_valid      <= 1'b0;
    if (rd_req_en === 1'b1) begin
      rsp_addr.push_back(rd_req_addr);
      rsp_tag.push_back(rd_req_tag);
      rsp_due.push_back(cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 6));
    end
    if (rsp_due.size() != 0 && rsp_due[0] <= cycle) begin
      a = rsp_addr.pop_front();
      t = rsp_tag.pop_front();
      void'(rsp_due.pop_front());
      rd_rsp_valid <= 1'b1;
      rd_rsp_tag   <= t;
      rd_rsp_data  <= shared_mem[a];
    end
  end

  // request monitor
  always @(posedge clk) begin
    if (rd_req_en === 1'b1) begin
      if (rd_af_seen) begin
        other_errors++;
        $display("read request issued in the cycle after almost-full was high");
      end
      if (exp_rd_addr.size() == 0) begin
        other_errors++;
        $display("unexpected read request at address %h", rd_req_addr);
      end else begin
        check_addr("rd_req_addr", rd_req_addr, exp_rd_addr.pop_front());
        check_flag("rd_req_tag", rd_req_tag, exp_rd_tag.pop_front());
      end
    end
    if (wr_req_en === 1'b1) begin
      if (wr_af_seen) begin
        other_errors++;
        $display("write request issued in the cycle after almost-full was high");
      end
      if (exp_wr_addr.size() == 0) begin
        other_errors++;
        $display("unexpected write request at address %h", wr_req_addr);
      end else begin
        check_addr("wr_req_addr", wr_req_addr, exp_wr_addr.pop_front());
        check_line("wr_req_data", wr_req_data, exp_wr_data.pop_front());
      end
    end
    // done rises together with the last write of the job
    if (done_chk) begin
      check_flag("done", done, (wr_seen + (wr_req_en === 1'b1 ? 1 : 0)) == wr_target);
    end
    if (wr_req_en === 1'b1) begin
      wr_seen <= wr_seen + 1;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout after %0d cycles with the job still running", cycle);
      report_counts();
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    int                    p;
    int                    total;
    int                    f;
    conv_pkg::addr_t       ia;
    conv_pkg::addr_t       ka;
    conv_pkg::addr_t       da;
    conv_pkg::map_idx_t    nm;
    conv_pkg::filter_cnt_t nf;
    reset             = 1'b1;
    start             = 1'b0;
    image_addr        = '0;
    kernel_addr       = '0;
    dest_addr         = '0;
    num_maps          = '0;
    num_filters       = '0;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid      = 1'b0;
    rd_rsp_tag        = 1'b0;
    rd_rsp_data       = '0;
    rd_af_seen        = 1'b0;
    wr_af_seen        = 1'b0;
    done_chk          = 1'b0;
    cycle             = 0;
    wr_seen           = 0;
    wr_target         = 0;
    line_errors       = 0;
    addr_errors       = 0;
    flag_errors       = 0;
    other_errors      = 0;
    for (int a = 0; a < 2**16; a++) begin
      shared_mem[a] = fill_line(conv_pkg::addr_t'(a));
    end
    for (int i = 0; i < TRACE_WORDS; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh("testbench/conv_afu_trace.txt", trace_mem);

    // first pass sizes the timeout from the request count
    p     = 0;
    total = 0;
    while (p < TRACE_WORDS && trace_mem[p] != 0) begin
      case (trace_mem[p])
        1: begin
          total += int'(trace_mem[p+4]) * (1 + int'(trace_mem[p+5])) + int'(trace_mem[p+5]);
          p += 6;
        end
        2: p += 3;
        3: p += 2;
        default: begin
          other_errors++;
          $display("unknown record kind %h in the trace", trace_mem[p]);
          p = TRACE_WORDS;
        end
      endcase
    end
    cycle_limit = 40 * total;

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    p = 0;
    while (p < TRACE_WORDS && trace_mem[p] == 1) begin
      ia = trace_mem[p+1][15:0];
      ka = trace_mem[p+2][15:0];
      da = trace_mem[p+3][15:0];
      nm = trace_mem[p+4][4:0];
      nf = trace_mem[p+5][7:0];
      p += 6;
      f = 0;
      while (trace_mem[p] == 2 || trace_mem[p] == 3) begin
        if (trace_mem[p] == 2) begin
          shared_mem[trace_mem[p+1][15:0]] = trace_mem[p+2];
          p += 3;
        end else begin
          exp_wr_addr.push_back(da + conv_pkg::addr_t'(f));
          exp_wr_data.push_back(trace_mem[p+1]);
          f++;
          p += 2;
        end
      end
      for (int i = 0; i < nm; i++) begin
        exp_rd_addr.push_back(ia + conv_pkg::addr_t'(i));
        exp_rd_tag.push_back(1'b0);
      end
      for (int i = 0; i < nm * nf; i++) begin
        exp_rd_addr.push_back(ka + conv_pkg::addr_t'(i));
        exp_rd_tag.push_back(1'b1);
      end

      @(posedge clk);
      // done of the previous job is still high until start is taken
      done_chk    <= 1'b0;
      wr_target   <= wr_seen + nf;
      image_addr  <= ia;
      kernel_addr <= ka;
      dest_addr   <= da;
      num_maps    <= nm;
      num_filters <= nf;
      start       <= 1'b1;
      @(posedge clk);
      start    <= 1'b0;
      done_chk <= 1'b1;
      @(posedge clk);
      while (!(wr_seen == wr_target && done === 1'b1)) begin
        @(posedge clk);
      end
      repeat (4) @(posedge clk);
    end

    if (exp_rd_addr.size() != 0) begin
      other_errors++;
      $display("%0d expected read requests never appeared", exp_rd_addr.size());
    end
    if (exp_wr_addr.size() != 0) begin
      other_errors++;
      $display("%0d expected write requests never appeared", exp_wr_addr.size());
    end
    report_counts();
    if (line_errors + addr_errors + flag_errors + other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/conv_afu_trace.txt
// kind 1: job with image_addr kernel_addr dest_addr num_maps num_filters
// kind 2: memory line with addr data, kind 3: expected output line, kind 0: end of trace
// job 1: two maps, two filters, complex values in Q8
1 0010 0020 0040 2 2
2 0010 0080ff0002000100
2 0011 00000040fe000300
2 0020 ff00020001000100
2 0021 0100010000000080
2 0022 0000ff8001000000
2 0023 0200000000000100
3 0240fec002000080
3 00400080ff000100
// job 2: sixteen maps, three filters, all lines from the address fill pattern
1 0100 0200 0300 10 3
3 0000de930000216c
3 0000dd8b00002274
3 0000dc840000237b
0
